//--- include/mmu_config.svh
/*
  Sv39 data MMU geometry.
  Widths assume a 64-bit core with 39-bit virtual and 56-bit physical
  addresses. The walker and check stage are written for three levels of
  9-bit VPN slices; changing MMU_LEVELS or MMU_VPN_BITS alone is not enough.
*/
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// address widths
`define MMU_VLEN 39
`define MMU_PLEN 56
`define MMU_PPNW 44

// page geometry
`define MMU_PAGE_OFFSET 12
`define MMU_VPN_BITS 9
`define MMU_LEVELS 3

// default number of data TLB entries
`define MMU_TLB_ENTRIES 4

// walker memory port
`define MMU_WB_DW 64

`endif

//--- logic/sv39_pkg.sv
/*
  Architectural Sv39 types.
  Only U and S privilege are modelled; machine mode never reaches the MMU.
  pte_t follows the in-memory layout of a 64-bit page table entry.
*/
`include "mmu_config.svh"

package sv39_pkg;

    // privilege of the load/store access
    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_S = 2'b01
    } priv_lvl_e;

    // page table entry as read from memory
    typedef struct packed {
        logic [9:0]            reserved;
        logic [`MMU_PPNW-1:0]  ppn;
        logic [1:0]            rsw;
        logic                  d;
        logic                  a;
        logic                  g;
        logic                  u;
        logic                  x;
        logic                  w;
        logic                  r;
        logic                  v;
    } pte_t;

    // virtual page number, level 2 slice on top
    typedef struct packed {
        logic [`MMU_VPN_BITS-1:0] vpn2;
        logic [`MMU_VPN_BITS-1:0] vpn1;
        logic [`MMU_VPN_BITS-1:0] vpn0;
    } vpn_t;

endpackage

//--- logic/mmu_pkg.sv
/*
  Implementation types of the data MMU.
  Cause codes are the RISC-V mcause values for load and store page faults.
  page_size_e is shared by the TLB entries, walker refills and the
  physical address composition.
*/

package mmu_pkg;

    // exception causes raised by the MMU
    typedef enum logic [5:0] {
        LOAD_PAGE_FAULT  = 6'd13,
        STORE_PAGE_FAULT = 6'd15
    } exc_cause_e;

    // page table walker FSM
    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        CHECK_PTE,
        DONE_FAULT
    } ptw_state_e;

    // size of a mapped page
    typedef enum logic [1:0] {
        PAGE_4K,
        PAGE_2M,
        PAGE_1G
    } page_size_e;

endpackage

//--- logic/dtlb.sv
/*
  Fully associative data TLB.
  Lookup is combinational on lu_vaddr_i. Refills go to a round-robin victim,
  so an entry already present is never checked for on update. A flush
  drops every entry at the next edge and wins over a refill in that cycle.
*/
`timescale 1ns/1ps
`include "mmu_config.svh"

module dtlb #(
    parameter int unsigned TLB_ENTRIES = `MMU_TLB_ENTRIES
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  logic [`MMU_VLEN-1:0]   lu_vaddr_i,
    input  logic                   upd_valid_i,
    input  sv39_pkg::vpn_t         upd_vpn_i,
    input  sv39_pkg::pte_t         upd_pte_i,
    input  mmu_pkg::page_size_e    upd_size_i,
    output logic                   lu_hit_o,
    output sv39_pkg::pte_t         lu_pte_o,
    output mmu_pkg::page_size_e    lu_size_o
);
    import sv39_pkg::*;
    import mmu_pkg::*;

    localparam int unsigned RR_W = $clog2(TLB_ENTRIES);

    vpn_t                   tag_q  [TLB_ENTRIES];
    pte_t                   pte_q  [TLB_ENTRIES];
    page_size_e             size_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] valid_q;
    logic [RR_W-1:0]        rr_q;
    logic [TLB_ENTRIES-1:0] match;
    vpn_t                   lu_vpn;

    assign lu_vpn = vpn_t'(lu_vaddr_i[`MMU_VLEN-1:`MMU_PAGE_OFFSET]);

    // ------------------------------
    // lookup
    // ------------------------------
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            // superpages ignore the lower slices
            match[i] = valid_q[i]
                     && (tag_q[i].vpn2 == lu_vpn.vpn2)
                     && ((size_q[i] == PAGE_1G) || (tag_q[i].vpn1 == lu_vpn.vpn1))
                     && ((size_q[i] != PAGE_4K) || (tag_q[i].vpn0 == lu_vpn.vpn0));
        end
    end

    always_comb begin
        lu_hit_o  = |match;
        lu_pte_o  = '0;
        lu_size_o = PAGE_4K;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                lu_pte_o  = pte_q[i];
                lu_size_o = size_q[i];
            end
        end
    end

    // ------------------------------
    // refill and flush
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (upd_valid_i) begin
            valid_q[rr_q] <= 1'b1;
            // wrap explicitly, depth need not be a power of two
            if (rr_q == RR_W'(TLB_ENTRIES - 1)) begin
                rr_q <= '0;
            end else begin
                rr_q <= rr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (upd_valid_i) begin
            tag_q[rr_q]  <= upd_vpn_i;
            pte_q[rr_q]  <= upd_pte_i;
            size_q[rr_q] <= upd_size_i;
        end
    end

endmodule

//--- logic/ptw.sv
/*
  Sv39 page table walker with a Wishbone classic read master.
  One read per level, starting from satp_ppn_i. Misses seen while a walk
  is in progress are ignored; the LSU keeps its request up, so the lookup
  is retried once the refill lands. The A and D bits are never written
  back, a clear bit is reported later as a page fault.
*/
`timescale 1ns/1ps
`include "mmu_config.svh"

module ptw (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   enable_i,
    input  logic                   miss_i,
    input  logic [`MMU_VLEN-1:0]   vaddr_i,
    input  logic [`MMU_PPNW-1:0]   satp_ppn_i,
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic [`MMU_PLEN-1:0]   wb_adr_o,
    input  logic [`MMU_WB_DW-1:0]  wb_dat_i,
    input  logic                   wb_ack_i,
    output logic                   upd_valid_o,
    output sv39_pkg::vpn_t         upd_vpn_o,
    output sv39_pkg::pte_t         upd_pte_o,
    output mmu_pkg::page_size_e    upd_size_o,
    output logic                   fault_o
);
    import sv39_pkg::*;
    import mmu_pkg::*;

    localparam int unsigned LVL_W = $clog2(`MMU_LEVELS);

    ptw_state_e               state_q;
    logic [LVL_W-1:0]         level_q;
    logic [`MMU_PPNW-1:0]     tbl_ppn_q;
    logic [`MMU_VLEN-1:0]     vaddr_q;
    pte_t                     pte_q;
    vpn_t                     vpn;
    logic [`MMU_VPN_BITS-1:0] vpn_slice;
    logic                     start;
    logic                     leaf;
    logic                     pte_bad;
    logic                     misaligned;
    logic                     walk_err;
    page_size_e               leaf_size;

    assign vpn   = vpn_t'(vaddr_q[`MMU_VLEN-1:`MMU_PAGE_OFFSET]);
    assign start = (state_q == IDLE) && enable_i && miss_i;

    // slice and page size for the current level
    always_comb begin
        case (level_q)
            LVL_W'(2): begin
                vpn_slice  = vpn.vpn2;
                leaf_size  = PAGE_1G;
                misaligned = |pte_q.ppn[2*`MMU_VPN_BITS-1:0];
            end
            LVL_W'(1): begin
                vpn_slice  = vpn.vpn1;
                leaf_size  = PAGE_2M;
                misaligned = |pte_q.ppn[`MMU_VPN_BITS-1:0];
            end
            default: begin
                vpn_slice  = vpn.vpn0;
                leaf_size  = PAGE_4K;
                misaligned = 1'b0;
            end
        endcase
    end

    // ------------------------------
    // PTE decode
    // ------------------------------
    assign pte_bad  = !pte_q.v || (pte_q.w && !pte_q.r);
    assign leaf     = pte_q.r || pte_q.x;
    // a pointer at the last level has nowhere to go
    assign walk_err = pte_bad || (leaf && misaligned) || (!leaf && (level_q == '0));

    // ------------------------------
    // FSM
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            level_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q <= WAIT_ACK;
                        level_q <= LVL_W'(`MMU_LEVELS - 1);
                    end
                end
                WAIT_ACK: begin
                    if (wb_ack_i) begin
                        state_q <= CHECK_PTE;
                    end
                end
                CHECK_PTE: begin
                    if (walk_err) begin
                        state_q <= DONE_FAULT;
                    end else if (leaf) begin
                        state_q <= IDLE;
                    end else begin
                        state_q <= WAIT_ACK;
                        level_q <= level_q - 1'b1;
                    end
                end
                DONE_FAULT: state_q <= IDLE;
                default:    state_q <= IDLE;
            endcase
        end
    end

    // walk payload
    always_ff @(posedge clk_i) begin
        if (start) begin
            vaddr_q   <= vaddr_i;
            tbl_ppn_q <= satp_ppn_i;
        end
        if ((state_q == WAIT_ACK) && wb_ack_i) begin
            pte_q <= pte_t'(wb_dat_i);
        end
        if ((state_q == CHECK_PTE) && !walk_err && !leaf) begin
            tbl_ppn_q <= pte_q.ppn;
        end
    end

    // ------------------------------
    // outputs
    // ------------------------------
    // cyc drops in CHECK_PTE, so there is an idle cycle between reads
    assign wb_cyc_o = (state_q == WAIT_ACK);
    assign wb_stb_o = (state_q == WAIT_ACK);
    // 8-byte entries
    assign wb_adr_o = {tbl_ppn_q, vpn_slice, 3'b000};

    assign upd_valid_o = (state_q == CHECK_PTE) && leaf && !walk_err;
    assign upd_vpn_o   = vpn;
    assign upd_pte_o   = pte_q;
    assign upd_size_o  = leaf_size;
    assign fault_o     = (state_q == DONE_FAULT);

endmodule

//--- logic/dmmu_check.sv
/*
  Response stage of the data MMU.
  A request is registered when it hits, when translation is off, or when
  the walker reports a fault for it, and is answered one cycle later.
  Page faults cover U/S with SUM, a clear A bit, and stores to pages
  without W or D. tval is the untranslated virtual address.
*/
`timescale 1ns/1ps
`include "mmu_config.svh"

module dmmu_check (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   enable_i,
    input  logic                   req_i,
    input  logic [`MMU_VLEN-1:0]   vaddr_i,
    input  logic                   is_store_i,
    input  sv39_pkg::priv_lvl_e    priv_lvl_i,
    input  logic                   sum_i,
    input  logic                   hit_i,
    input  sv39_pkg::pte_t         pte_i,
    input  mmu_pkg::page_size_e    size_i,
    input  logic                   walk_fault_i,
    output logic                   miss_o,
    output logic                   valid_o,
    output logic [`MMU_PLEN-1:0]   paddr_o,
    output logic                   ex_valid_o,
    output mmu_pkg::exc_cause_e    ex_cause_o,
    output logic [`MMU_VLEN-1:0]   ex_tval_o
);
    import sv39_pkg::*;
    import mmu_pkg::*;

    // top bits of the vaddr kept for 2M and 1G pages
    localparam int unsigned MEGA_HI = `MMU_PAGE_OFFSET + `MMU_VPN_BITS - 1;
    localparam int unsigned GIGA_HI = `MMU_PAGE_OFFSET + 2 * `MMU_VPN_BITS - 1;

    logic                 accept;
    logic                 valid_q;
    logic                 en_q;
    logic                 walk_fault_q;
    logic [`MMU_VLEN-1:0] vaddr_q;
    logic                 store_q;
    priv_lvl_e            priv_q;
    logic                 sum_q;
    pte_t                 pte_q;
    page_size_e           size_q;
    logic                 priv_err;
    logic                 perm_err;

    assign miss_o = enable_i && req_i && !hit_i;
    assign accept = req_i && (!enable_i || hit_i || walk_fault_i);

    // ------------------------------
    // response register
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q      <= 1'b0;
            en_q         <= 1'b0;
            walk_fault_q <= 1'b0;
        end else begin
            valid_q      <= accept;
            en_q         <= enable_i;
            walk_fault_q <= walk_fault_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q <= vaddr_i;
        store_q <= is_store_i;
        priv_q  <= priv_lvl_i;
        sum_q   <= sum_i;
        pte_q   <= pte_i;
        size_q  <= size_i;
    end

    // ------------------------------
    // physical address
    // ------------------------------
    always_comb begin
        if (en_q) begin
            paddr_o = {pte_q.ppn, vaddr_q[`MMU_PAGE_OFFSET-1:0]};
            if (size_q == PAGE_2M) begin
                paddr_o[MEGA_HI:`MMU_PAGE_OFFSET] = vaddr_q[MEGA_HI:`MMU_PAGE_OFFSET];
            end
            if (size_q == PAGE_1G) begin
                paddr_o[GIGA_HI:`MMU_PAGE_OFFSET] = vaddr_q[GIGA_HI:`MMU_PAGE_OFFSET];
            end
        end else begin
            // bare mode, zero-extend
            paddr_o = {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, vaddr_q};
        end
    end

    // ------------------------------
    // permission checks
    // ------------------------------
    // S mode may touch user pages only with SUM set
    assign priv_err = ((priv_q == PRIV_LVL_S) && pte_q.u && !sum_q)
                   || ((priv_q == PRIV_LVL_U) && !pte_q.u);
    assign perm_err = priv_err || !pte_q.a || (store_q && (!pte_q.w || !pte_q.d));

    assign valid_o    = valid_q;
    assign ex_valid_o = valid_q && en_q && (walk_fault_q || perm_err);
    assign ex_cause_o = store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
    assign ex_tval_o  = vaddr_q;

endmodule

//--- logic/dmmu_top.sv
/*
  Data MMU top level for an Sv39 core.
  The LSU must hold its request until lsu_valid_o. The walker reads page
  tables over Wishbone classic and never writes, so no we signal exists.
  No PMP or PMA checking is done on the translated address.
*/
`timescale 1ns/1ps
`include "mmu_config.svh"

module dmmu_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // LSU
    input  logic                   lsu_req_i,
    input  logic [`MMU_VLEN-1:0]   lsu_vaddr_i,
    input  logic                   lsu_is_store_i,
    output logic                   lsu_valid_o,
    output logic [`MMU_PLEN-1:0]   lsu_paddr_o,
    output logic                   lsu_ex_valid_o,
    output mmu_pkg::exc_cause_e    lsu_ex_cause_o,
    output logic [`MMU_VLEN-1:0]   lsu_ex_tval_o,
    // CSR state
    input  logic                   enable_translation_i,
    input  sv39_pkg::priv_lvl_e    priv_lvl_i,
    input  logic                   sum_i,
    input  logic [`MMU_PPNW-1:0]   satp_ppn_i,
    input  logic                   flush_tlb_i,
    // page table reads
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic [`MMU_PLEN-1:0]   wb_adr_o,
    input  logic [`MMU_WB_DW-1:0]  wb_dat_i,
    input  logic                   wb_ack_i
);
    import sv39_pkg::*;
    import mmu_pkg::*;

    logic       dtlb_hit;
    pte_t       dtlb_pte;
    page_size_e dtlb_size;
    logic       miss;
    logic       upd_valid;
    vpn_t       upd_vpn;
    pte_t       upd_pte;
    page_size_e upd_size;
    logic       walk_fault;

    dtlb u_dtlb (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_tlb_i),
        .lu_vaddr_i  (lsu_vaddr_i),
        .upd_valid_i (upd_valid),
        .upd_vpn_i   (upd_vpn),
        .upd_pte_i   (upd_pte),
        .upd_size_i  (upd_size),
        .lu_hit_o    (dtlb_hit),
        .lu_pte_o    (dtlb_pte),
        .lu_size_o   (dtlb_size)
    );

    ptw u_ptw (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .enable_i    (enable_translation_i),
        .miss_i      (miss),
        .vaddr_i     (lsu_vaddr_i),
        .satp_ppn_i  (satp_ppn_i),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .upd_valid_o (upd_valid),
        .upd_vpn_o   (upd_vpn),
        .upd_pte_o   (upd_pte),
        .upd_size_o  (upd_size),
        .fault_o     (walk_fault)
    );

    dmmu_check u_check (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .enable_i     (enable_translation_i),
        .req_i        (lsu_req_i),
        .vaddr_i      (lsu_vaddr_i),
        .is_store_i   (lsu_is_store_i),
        .priv_lvl_i   (priv_lvl_i),
        .sum_i        (sum_i),
        .hit_i        (dtlb_hit),
        .pte_i        (dtlb_pte),
        .size_i       (dtlb_size),
        .walk_fault_i (walk_fault),
        .miss_o       (miss),
        .valid_o      (lsu_valid_o),
        .paddr_o      (lsu_paddr_o),
        .ex_valid_o   (lsu_ex_valid_o),
        .ex_cause_o   (lsu_ex_cause_o),
        .ex_tval_o    (lsu_ex_tval_o)
    );

endmodule

//--- tb/tb_dmmu.sv
/*
  Testbench for the Sv39 data MMU.
  Page tables live in a small three-table memory behind a Wishbone slave
  model; any address outside those tables reads as an invalid PTE.
  The LSU side holds each request until lsu_valid_o and leaves one idle
  cycle between requests, so back-to-back hits are not exercised.
  Ack delays are 0 in the directed part and 0 to 3 cycles in the random rounds.
*/
`timescale 1ns/1ps
`include "mmu_config.svh"

module tb_dmmu;
    import sv39_pkg::*;
    import mmu_pkg::*;

    localparam int unsigned TBL_WORDS  = 512;
    localparam int unsigned WAIT_LIMIT = 64;

    // root, level 1 and level 0 tables sit on consecutive pages
    localparam logic [`MMU_PPNW-1:0] ROOT_PPN = 44'h80000;
    localparam logic [`MMU_PPNW-1:0] PPN_4K   = 44'h55501;
    localparam logic [`MMU_PPNW-1:0] PPN_RO   = 44'h55502;
    localparam logic [`MMU_PPNW-1:0] PPN_ND   = 44'h55503;
    localparam logic [`MMU_PPNW-1:0] PPN_USER = 44'h55504;
    localparam logic [`MMU_PPNW-1:0] PPN_INV  = 44'h55505;
    localparam logic [`MMU_PPNW-1:0] PPN_2M   = 44'h40200;

    localparam logic [`MMU_VLEN-1:0] VA_4K   = 39'h1abc;
    localparam logic [`MMU_VLEN-1:0] VA_RO   = 39'h2010;
    localparam logic [`MMU_VLEN-1:0] VA_ND   = 39'h3020;
    localparam logic [`MMU_VLEN-1:0] VA_USER = 39'h4030;
    localparam logic [`MMU_VLEN-1:0] VA_INV  = 39'h5040;
    localparam logic [`MMU_VLEN-1:0] VA_2M   = 39'h35_6789;

    // PTE flag bits, d a g u x w r v from bit 7 down
    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_U = 8'h10;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  lsu_req_i;
    logic [`MMU_VLEN-1:0]  lsu_vaddr_i;
    logic                  lsu_is_store_i;
    logic                  lsu_valid_o;
    logic [`MMU_PLEN-1:0]  lsu_paddr_o;
    logic                  lsu_ex_valid_o;
    exc_cause_e            lsu_ex_cause_o;
    logic [`MMU_VLEN-1:0]  lsu_ex_tval_o;
    logic                  enable_translation_i;
    priv_lvl_e             priv_lvl_i;
    logic                  sum_i;
    logic [`MMU_PPNW-1:0]  satp_ppn_i;
    logic                  flush_tlb_i;
    logic                  wb_cyc_o;
    logic                  wb_stb_o;
    logic [`MMU_PLEN-1:0]  wb_adr_o;
    logic [`MMU_WB_DW-1:0] wb_dat_i;
    logic                  wb_ack_i;

    logic [63:0] pt_mem [3*TBL_WORDS];

    // expectation for the request in flight
    logic                 exp_hit;
    logic                 exp_fault;
    logic [`MMU_PLEN-1:0] exp_paddr;
    logic [`MMU_VLEN-1:0] exp_tval;
    exc_cause_e           exp_cause;

    int unsigned cyc_count = 0;
    int unsigned cyc_base;
    int unsigned mismatches;
    int unsigned failures;
    logic        random_ack;

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        if (wb_cyc_o) begin
            cyc_count <= cyc_count + 1;
        end
    end

    dmmu_top u_dut (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .lsu_req_i            (lsu_req_i),
        .lsu_vaddr_i          (lsu_vaddr_i),
        .lsu_is_store_i       (lsu_is_store_i),
        .lsu_valid_o          (lsu_valid_o),
        .lsu_paddr_o          (lsu_paddr_o),
        .lsu_ex_valid_o       (lsu_ex_valid_o),
        .lsu_ex_cause_o       (lsu_ex_cause_o),
        .lsu_ex_tval_o        (lsu_ex_tval_o),
        .enable_translation_i (enable_translation_i),
        .priv_lvl_i           (priv_lvl_i),
        .sum_i                (sum_i),
        .satp_ppn_i           (satp_ppn_i),
        .flush_tlb_i          (flush_tlb_i),
        .wb_cyc_o             (wb_cyc_o),
        .wb_stb_o             (wb_stb_o),
        .wb_adr_o             (wb_adr_o),
        .wb_dat_i             (wb_dat_i),
        .wb_ack_i             (wb_ack_i)
    );

    // ------------------------------
    // page table memory
    // ------------------------------
    function automatic logic [63:0] make_pte(input logic [`MMU_PPNW-1:0] ppn,
                                             input logic [7:0] flags);
        return {10'b0, ppn, 2'b00, flags};
    endfunction

    function automatic logic [63:0] read_pte(input logic [`MMU_PLEN-1:0] adr);
        logic [`MMU_PPNW-1:0] ppn;
        logic [63:0]          data;
        ppn  = adr[`MMU_PLEN-1:12];
        data = '0;
        if ((ppn >= ROOT_PPN) && (ppn < ROOT_PPN + 3)) begin
            data = pt_mem[int'(ppn - ROOT_PPN) * TBL_WORDS + int'(adr[11:3])];
        end
        return data;
    endfunction

    task automatic build_tables();
        // unused slots carry their index in the ppn field but stay invalid
        for (int i = 0; i < 3 * TBL_WORDS; i++) begin
            pt_mem[i] = 64'(i) << 10;
        end
        pt_mem[0]             = make_pte(ROOT_PPN + 1, F_V);
        pt_mem[TBL_WORDS + 0] = make_pte(ROOT_PPN + 2, F_V);
        pt_mem[TBL_WORDS + 1] = make_pte(PPN_2M, F_V | F_R | F_W | F_A | F_D);
        pt_mem[2*TBL_WORDS + 1] = make_pte(PPN_4K, F_V | F_R | F_W | F_A | F_D);
        pt_mem[2*TBL_WORDS + 2] = make_pte(PPN_RO, F_V | F_R | F_A | F_D);
        pt_mem[2*TBL_WORDS + 3] = make_pte(PPN_ND, F_V | F_R | F_W | F_A);
        pt_mem[2*TBL_WORDS + 4] = make_pte(PPN_USER, F_V | F_R | F_W | F_A | F_D | F_U);
        // permissions present but v clear
        pt_mem[2*TBL_WORDS + 5] = make_pte(PPN_INV, F_R | F_W | F_A | F_D);
    endtask

    // Wishbone classic slave, one read per cycle with optional ack delay
    initial begin : wb_slave
        int wait_cnt;
        wb_ack_i = 1'b0;
        wb_dat_i = '0;
        void'($urandom(32'hf671));
        wait_cnt = -1;
        forever begin
            @(posedge clk_i);
            #1;
            if (wb_ack_i) begin
                wb_ack_i = 1'b0;
                wait_cnt = -1;
            end else if (wb_cyc_o && wb_stb_o) begin
                if (wait_cnt < 0) begin
                    wait_cnt = random_ack ? int'($urandom % 4) : 0;
                end
                if (wait_cnt == 0) begin
                    wb_dat_i = read_pte(wb_adr_o);
                    wb_ack_i = 1'b1;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // ------------------------------
    // expected addresses
    // ------------------------------
    function automatic logic [`MMU_PLEN-1:0] pa_bare(input logic [`MMU_VLEN-1:0] va);
        return {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, va};
    endfunction

    function automatic logic [`MMU_PLEN-1:0] pa_4k(input logic [`MMU_PPNW-1:0] ppn,
                                                   input logic [`MMU_VLEN-1:0] va);
        return {ppn, va[11:0]};
    endfunction

    // 2M page keeps vaddr bits 20:0
    function automatic logic [`MMU_PLEN-1:0] pa_2m(input logic [`MMU_PPNW-1:0] ppn,
                                                   input logic [`MMU_VLEN-1:0] va);
        return {ppn[`MMU_PPNW-1:9], va[20:0]};
    endfunction

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic access(input logic [`MMU_VLEN-1:0] va, input logic store,
                          input logic one_cycle, input logic fault,
                          input logic [`MMU_PLEN-1:0] pa);
        int n;
        exp_hit   = one_cycle;
        exp_fault = fault;
        exp_paddr = pa;
        exp_tval  = va;
        exp_cause = store ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
        cyc_base  = cyc_count;
        lsu_req_i      = 1'b1;
        lsu_vaddr_i    = va;
        lsu_is_store_i = store;
        n = 0;
        do begin
            @(posedge clk_i);
            #1;
            n++;
        end while (!lsu_valid_o && (n < WAIT_LIMIT));
        if (!lsu_valid_o) begin
            failures++;
            $display("request for vaddr %h got no response within %0d cycles", va, WAIT_LIMIT);
        end
        lsu_req_i = 1'b0;
        // the response is sampled at this edge
        @(posedge clk_i);
        #1;
    endtask

    task automatic pulse_flush();
        flush_tlb_i = 1'b1;
        @(posedge clk_i);
        #1;
        flush_tlb_i = 1'b0;
    endtask

    // four refills fill the TLB, the user page then evicts the 4K entry
    task automatic walk_round();
        pulse_flush();
        access(VA_4K, 1'b0, 1'b0, 1'b0, pa_4k(PPN_4K, VA_4K));
        access(VA_4K + 8, 1'b1, 1'b1, 1'b0, pa_4k(PPN_4K, VA_4K + 8));
        access(VA_2M, 1'b0, 1'b0, 1'b0, pa_2m(PPN_2M, VA_2M));
        access(VA_RO, 1'b1, 1'b0, 1'b1, '0);
        access(VA_ND, 1'b1, 1'b0, 1'b1, '0);
        sum_i = 1'b1;
        access(VA_USER, 1'b0, 1'b0, 1'b0, pa_4k(PPN_USER, VA_USER));
        sum_i = 1'b0;
        access(VA_INV, 1'b0, 1'b0, 1'b1, '0);
        access(VA_2M + 39'h100, 1'b0, 1'b1, 1'b0, pa_2m(PPN_2M, VA_2M + 39'h100));
    endtask

    initial begin
        rst_ni               = 1'b1;
        lsu_req_i            = 1'b0;
        lsu_vaddr_i          = '0;
        lsu_is_store_i       = 1'b0;
        enable_translation_i = 1'b0;
        priv_lvl_i           = PRIV_LVL_S;
        sum_i                = 1'b0;
        satp_ppn_i           = ROOT_PPN;
        flush_tlb_i          = 1'b0;
        random_ack           = 1'b0;
        exp_hit              = 1'b1;
        exp_fault            = 1'b0;
        exp_paddr            = '0;
        exp_tval             = '0;
        exp_cause            = LOAD_PAGE_FAULT;
        mismatches           = 0;
        failures             = 0;
        build_tables();

        #10;
        rst_ni = 1'b0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // bare mode
        access(39'h5a_c3f0_1234, 1'b0, 1'b1, 1'b0, pa_bare(39'h5a_c3f0_1234));
        access(39'h7f_ffff_fff8, 1'b1, 1'b1, 1'b0, pa_bare(39'h7f_ffff_fff8));

        // 4K and 2M pages, walk then hit
        enable_translation_i = 1'b1;
        access(VA_4K, 1'b0, 1'b0, 1'b0, pa_4k(PPN_4K, VA_4K));
        access(VA_4K + 16, 1'b1, 1'b1, 1'b0, pa_4k(PPN_4K, VA_4K + 16));
        access(VA_2M, 1'b0, 1'b0, 1'b0, pa_2m(PPN_2M, VA_2M));
        access(VA_2M + 39'h12000, 1'b1, 1'b1, 1'b0, pa_2m(PPN_2M, VA_2M + 39'h12000));

        // permission faults
        access(VA_RO, 1'b1, 1'b0, 1'b1, '0);
        access(VA_RO, 1'b0, 1'b1, 1'b0, pa_4k(PPN_RO, VA_RO));
        access(VA_ND, 1'b1, 1'b0, 1'b1, '0);
        access(VA_USER, 1'b0, 1'b0, 1'b1, '0);
        sum_i = 1'b1;
        access(VA_USER, 1'b0, 1'b1, 1'b0, pa_4k(PPN_USER, VA_USER));
        sum_i      = 1'b0;
        priv_lvl_i = PRIV_LVL_U;
        access(VA_USER, 1'b0, 1'b1, 1'b0, pa_4k(PPN_USER, VA_USER));
        access(VA_RO, 1'b0, 1'b1, 1'b1, '0);
        priv_lvl_i = PRIV_LVL_S;

        // invalid entry, then flush forces a new walk
        access(VA_INV, 1'b0, 1'b0, 1'b1, '0);
        access(VA_INV, 1'b1, 1'b0, 1'b1, '0);
        access(VA_2M, 1'b0, 1'b1, 1'b0, pa_2m(PPN_2M, VA_2M));
        pulse_flush();
        access(VA_2M, 1'b0, 1'b0, 1'b0, pa_2m(PPN_2M, VA_2M));

        random_ack = 1'b1;
        repeat (3) walk_round();

        repeat (4) @(posedge clk_i);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if ((mismatches == 0) && (failures == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // ------------------------------
    // checks
    // ------------------------------
    a_reset: assert property (@(posedge clk_i)
        !rst_ni |-> !lsu_valid_o && !lsu_ex_valid_o && !wb_cyc_o && !wb_stb_o)
    else begin
        failures++;
        $display("outputs not idle while reset is asserted");
    end

    a_paddr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_o && !exp_fault |-> lsu_paddr_o == exp_paddr)
    else begin
        mismatches++;
        $display("mismatch lsu_paddr_o: got %h, expected %h", $sampled(lsu_paddr_o),
                 $sampled(exp_paddr));
    end

    a_no_ex: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_o && !exp_fault |-> !lsu_ex_valid_o)
    else begin
        mismatches++;
        $display("mismatch lsu_ex_valid_o: got %h, expected %h", $sampled(lsu_ex_valid_o), 1'b0);
    end

    a_ex_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_o && exp_fault |-> lsu_ex_valid_o)
    else begin
        mismatches++;
        $display("mismatch lsu_ex_valid_o: got %h, expected %h", $sampled(lsu_ex_valid_o), 1'b1);
    end

    a_ex_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_o && exp_fault |-> lsu_ex_cause_o == exp_cause)
    else begin
        mismatches++;
        $display("mismatch lsu_ex_cause_o: got %h, expected %h", $sampled(lsu_ex_cause_o),
                 $sampled(exp_cause));
    end

    a_ex_tval: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_o && exp_fault |-> lsu_ex_tval_o == exp_tval)
    else begin
        mismatches++;
        $display("mismatch lsu_ex_tval_o: got %h, expected %h", $sampled(lsu_ex_tval_o),
                 $sampled(exp_tval));
    end

    // hits and bare mode answer one cycle after the request
    a_hit_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(lsu_req_i) && exp_hit |=> lsu_valid_o)
    else begin
        failures++;
        $display("request expected to hit was not answered one cycle later");
    end

    a_hit_no_walk: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_req_i && exp_hit |-> !wb_cyc_o)
    else begin
        failures++;
        $display("walker started a Wishbone read for a request that should hit");
    end

    a_miss_walked: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_o && !exp_hit |-> cyc_count != cyc_base)
    else begin
        failures++;
        $display("request answered without a page table walk where one was expected");
    end

    a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_o |=> !lsu_valid_o)
    else begin
        failures++;
        $display("lsu_valid_o stayed high for more than one cycle");
    end

    a_wb_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_cyc_o |-> wb_stb_o)
    else begin
        failures++;
        $display("Wishbone cycle open without strobe");
    end

    a_wb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_cyc_o && !wb_ack_i |=> wb_cyc_o && $stable(wb_adr_o))
    else begin
        failures++;
        $display("Wishbone request dropped or address changed before ack");
    end

    a_wb_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_ack_i |=> !wb_cyc_o)
    else begin
        failures++;
        $display("Wishbone cycle not closed for a cycle after ack");
    end

endmodule

//--- filelist.f
+incdir+include
logic/sv39_pkg.sv
logic/mmu_pkg.sv
logic/dtlb.sv
logic/ptw.sv
logic/dmmu_check.sv
logic/dmmu_top.sv
tb/tb_dmmu.sv

//--- Bender.yml
package:
  name: dmmu

export_include_dirs:
  - include

sources:
  # design, packages first
  - include_dirs:
      - include
    files:
      - logic/sv39_pkg.sv
      - logic/mmu_pkg.sv
      - logic/dtlb.sv
      - logic/ptw.sv
      - logic/dmmu_check.sv
      - logic/dmmu_top.sv

  # testbench, top module tb_dmmu
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_dmmu.sv
